//--- mem_subsys_top.f
+incdir+rtl
rtl/mem_subsys_pkg.sv
rtl/sram_2p.sv
rtl/dcache_banks.sv
rtl/icache_array.sv
rtl/mem_ctrl.sv
rtl/mem_subsys_top.sv
tests/ext_mem_model.sv
tests/mem_subsys_props.sv
tests/tb_mem_subsys.sv

//--- rtl/dcache_banks.sv
`timescale 1ns/10ps

module dcache_banks (
    input  logic                       clk,
    input  logic                       arst_n,

    input  mem_subsys_pkg::sram_port_t fill,
    output logic [31:0]                fill_rdata,

    input  mem_subsys_pkg::sram_port_t core_wr,
    input  mem_subsys_pkg::dread_req_t core_rd,
    output logic [31:0]                rdata,
    output logic                       wbusy
);
    import mem_subsys_pkg::*;

    localparam int BANK_DEPTH = 512;

    sram_port_t  bank_a  [2];
    logic [31:0] a_rdata [2];
    logic [31:0] b_rdata [2];
    logic        fill_sel_q;
    logic        rd_sel_q;

    // ============================================================
    // Even bank holds addr[0] == 0, odd bank addr[0] == 1
    // ============================================================
    for (genvar b = 0; b < 2; b++) begin : g_bank
        // Fill takes port a of the bank it addresses, core write gets the rest
        assign bank_a[b] = (fill.ce && fill.addr[0] == 1'(b)) ? fill : core_wr;

        sram_2p #(
            .word_t (logic [31:0]),
            .DEPTH  (BANK_DEPTH)
        ) i_sram (
            .clk     (clk),
            .a_ce    (bank_a[b].ce && bank_a[b].addr[0] == 1'(b)),
            .a_we    (bank_a[b].we),
            .a_wm    (bank_a[b].wm),
            .a_addr  (bank_a[b].addr[9:1]),
            .a_wdata (bank_a[b].data),
            .a_rdata (a_rdata[b]),
            .b_ce    (core_rd.re && core_rd.raddr[0] == 1'(b)),
            .b_addr  (core_rd.raddr[9:1]),
            .b_rdata (b_rdata[b])
        );
    end

    // A core write into the bank the fill owns is held off
    assign wbusy = fill.ce && core_wr.ce && core_wr.we &&
                   (fill.addr[0] == core_wr.addr[0]);

    // ============================================================
    // Read steering
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_sel_q <= 1'b0;
            rd_sel_q   <= 1'b0;
        end else begin
            if (fill.ce && !fill.we) begin
                fill_sel_q <= fill.addr[0];
            end
            if (core_rd.re) begin
                rd_sel_q <= core_rd.raddr[0];
            end
        end
    end

    assign fill_rdata = a_rdata[fill_sel_q];
    assign rdata      = b_rdata[rd_sel_q];

endmodule

//--- rtl/icache_array.sv
`timescale 1ns/10ps

module icache_array (
    input  logic                       clk,

    input  mem_subsys_pkg::sram_port_t fill,

    input  logic                       fetch_en,
    input  logic [7:0]                 fetch_idx,
    output logic [127:0]               fetch_data,
    output logic                       fetch_busy
);

    localparam int ENTRIES = 512;

    logic        a_ce;
    logic        a_we;
    logic [7:0]  a_wm;
    logic [8:0]  a_addr;
    logic [63:0] a_rdata;
    logic [63:0] b_rdata;

    // Fill owns port a, otherwise it reads the upper half of the line
    always_comb begin
        if (fill.ce) begin
            a_ce   = 1'b1;
            a_we   = fill.we;
            // addr[0] picks the 32-bit half of the entry
            a_wm   = fill.addr[0] ? {fill.wm, 4'h0} : {4'h0, fill.wm};
            a_addr = fill.addr[9:1];
        end else begin
            a_ce   = fetch_en;
            a_we   = 1'b0;
            a_wm   = '0;
            a_addr = {fetch_idx, 1'b1};
        end
    end

    sram_2p #(
        .word_t (logic [63:0]),
        .DEPTH  (ENTRIES)
    ) i_sram (
        .clk     (clk),
        .a_ce    (a_ce),
        .a_we    (a_we),
        .a_wm    (a_wm),
        .a_addr  (a_addr),
        .a_wdata ({fill.data, fill.data}),
        .a_rdata (a_rdata),
        .b_ce    (fetch_en),
        .b_addr  ({fetch_idx, 1'b0}),
        .b_rdata (b_rdata)
    );

    // Words 0/1 from the even entry, words 2/3 from the odd one
    assign fetch_data = {a_rdata, b_rdata};
    assign fetch_busy = fill.ce;

endmodule

//--- rtl/mem_ctrl.sv
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module mem_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,

    input  mem_subsys_pkg::apb_req_t   apb_req,
    output mem_subsys_pkg::apb_rsp_t   apb_rsp,

    output mem_subsys_pkg::sram_port_t dc_fill,
    output mem_subsys_pkg::sram_port_t ic_fill,
    input  logic [31:0]                dc_fill_rdata,

    output mem_subsys_pkg::ext_req_t   ext_req,
    input  mem_subsys_pkg::ext_rsp_t   ext_rsp,
    output logic                       xfer_done
);
    import mem_subsys_pkg::*;

    localparam int AW = $clog2(`MS_DC_WORDS);

    typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_WB} state_e;

    state_e       state;
    logic [29:0]  ext_addr;
    logic [AW-1:0] cache_addr;
    logic [AW:0]  len;
    xfer_target_e target;
    logic         wb_mode;
    logic [15:0]  done_cnt;

    logic [AW:0]  ext_cnt;
    logic [AW:0]  rd_cnt;
    logic         rd_vld;
    logic [31:0]  skid [2];
    logic         skid_wp;
    logic         skid_rp;
    logic [1:0]   skid_cnt;

    logic         busy;
    logic         apb_access;
    logic         apb_wr;
    logic         start;
    logic         beat;
    logic         last_beat;
    logic         rd_issue;
    logic         skid_pop;
    sram_port_t   fill_wr;

    assign busy       = (state != ST_IDLE);
    assign apb_access = apb_req.psel && apb_req.penable;
    // Register block is frozen while a transfer runs
    assign apb_wr     = apb_access && apb_req.pwrite && !busy;
    assign start      = apb_wr && (apb_req.paddr == `MS_REG_CTRL) &&
                        apb_req.pwdata[`MS_CTRL_START];

    // ============================================================
    // APB registers
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_addr   <= '0;
            cache_addr <= '0;
            len        <= '0;
            target     <= DCACHE;
            wb_mode    <= 1'b0;
        end else if (apb_wr) begin
            case (apb_req.paddr)
                `MS_REG_EXT_ADDR:   ext_addr   <= apb_req.pwdata[29:0];
                `MS_REG_CACHE_ADDR: cache_addr <= apb_req.pwdata[AW-1:0];
                `MS_REG_LEN:        len        <= apb_req.pwdata[AW:0];
                `MS_REG_CTRL: begin
                    target  <= apb_req.pwdata[`MS_CTRL_ICACHE] ? ICACHE : DCACHE;
                    wb_mode <= apb_req.pwdata[`MS_CTRL_WRITEBACK];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;
        case (apb_req.paddr)
            `MS_REG_EXT_ADDR:   apb_rsp.prdata = {2'b00, ext_addr};
            `MS_REG_CACHE_ADDR: apb_rsp.prdata = 32'(cache_addr);
            `MS_REG_LEN:        apb_rsp.prdata = 32'(len);
            `MS_REG_CTRL:       apb_rsp.prdata = {29'd0, wb_mode, target == ICACHE, 1'b0};
            `MS_REG_STATUS:     apb_rsp.prdata = {done_cnt, 15'd0, busy};
            default:            apb_rsp.pslverr = apb_access;
        endcase
    end

    // ============================================================
    // Transfer engine
    // ============================================================
    assign beat      = ext_req.en && !ext_rsp.stall;
    assign last_beat = beat && (ext_cnt == len - 1'b1);
    assign skid_pop  = (state == ST_WB) && beat;
    // Reads in flight plus buffered words never exceed two
    assign rd_issue  = (state == ST_WB) && (rd_cnt != len) &&
                       ((3'(skid_cnt) + 3'(rd_vld) - 3'(skid_pop)) < 3'd2);

    always_comb begin
        ext_req       = '0;
        ext_req.addr  = ext_addr + 30'(ext_cnt);
        ext_req.wdata = skid[skid_rp];
        if (state == ST_FILL) begin
            ext_req.en = 1'b1;
        end else if (state == ST_WB) begin
            ext_req.en = (skid_cnt != 2'd0);
            ext_req.we = 1'b1;
        end
    end

    always_comb begin
        fill_wr      = '0;
        fill_wr.ce   = 1'b1;
        fill_wr.we   = 1'b1;
        fill_wr.wm   = 4'hF;
        fill_wr.addr = cache_addr + AW'(ext_cnt);
        fill_wr.data = ext_rsp.rdata;

        dc_fill = '0;
        ic_fill = '0;
        if (state == ST_FILL && beat) begin
            if (target == ICACHE) begin
                ic_fill = fill_wr;
            end else begin
                dc_fill = fill_wr;
            end
        end else if (rd_issue) begin
            dc_fill.ce   = 1'b1;
            dc_fill.addr = cache_addr + AW'(rd_cnt);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            ext_cnt   <= '0;
            rd_cnt    <= '0;
            rd_vld    <= 1'b0;
            xfer_done <= 1'b0;
            done_cnt  <= '0;
        end else begin
            xfer_done <= 1'b0;
            rd_vld    <= rd_issue;
            if (beat) begin
                ext_cnt <= ext_cnt + 1'b1;
            end
            if (rd_issue) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    ext_cnt <= '0;
                    rd_cnt  <= '0;
                    if (start) begin
                        if (len == '0) begin
                            // Empty transfer completes at once
                            xfer_done <= 1'b1;
                            done_cnt  <= done_cnt + 1'b1;
                        end else if (apb_req.pwdata[`MS_CTRL_WRITEBACK]) begin
                            state <= ST_WB;
                        end else begin
                            state <= ST_FILL;
                        end
                    end
                end
                default: begin
                    if (last_beat) begin
                        state     <= ST_IDLE;
                        xfer_done <= 1'b1;
                        done_cnt  <= done_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Two-entry skid buffer between data cache reads and external writes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            skid_wp  <= 1'b0;
            skid_rp  <= 1'b0;
            skid_cnt <= '0;
        end else begin
            if (rd_vld) begin
                skid_wp <= ~skid_wp;
            end
            if (skid_pop) begin
                skid_rp <= ~skid_rp;
            end
            skid_cnt <= skid_cnt + 2'(rd_vld) - 2'(skid_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            skid[skid_wp] <= dc_fill_rdata;
        end
    end

endmodule

//--- rtl/mem_subsys_defs.svh
`ifndef MEM_SUBSYS_DEFS_SVH
`define MEM_SUBSYS_DEFS_SVH

// Array geometry
`define MS_DC_WORDS 1024
`define MS_IC_LINES 256

// ============================================================
// APB register map, byte offsets
// ============================================================
`define MS_REG_EXT_ADDR   8'h00
`define MS_REG_CACHE_ADDR 8'h04
`define MS_REG_LEN        8'h08
`define MS_REG_CTRL       8'h0C
`define MS_REG_STATUS     8'h10

// CTRL register bits
`define MS_CTRL_START     0
`define MS_CTRL_ICACHE    1
`define MS_CTRL_WRITEBACK 2

`endif

//--- rtl/mem_subsys_pkg.sv
package mem_subsys_pkg;

    // APB request from the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Write/fill port of the SRAM arrays, word addressed
    typedef struct packed {
        logic        ce;
        logic        we;
        logic [3:0]  wm;
        logic [9:0]  addr;
        logic [31:0] data;
    } sram_port_t;

    typedef struct packed {
        logic       re;
        logic [9:0] raddr;
    } dread_req_t;

    // External memory bus, word addressed
    typedef struct packed {
        logic        en;
        logic        we;
        logic [29:0] addr;
        logic [31:0] wdata;
    } ext_req_t;

    typedef struct packed {
        logic        stall;
        logic [31:0] rdata;
    } ext_rsp_t;

    typedef enum logic {DCACHE = 1'b0, ICACHE = 1'b1} xfer_target_e;

endpackage

//--- rtl/mem_subsys_top.sv
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module mem_subsys_top (
    input  logic                            clk,
    input  logic                            arst_n,

    input  mem_subsys_pkg::apb_req_t        apb_req,
    output mem_subsys_pkg::apb_rsp_t        apb_rsp,

    input  mem_subsys_pkg::sram_port_t      core_wr,
    input  mem_subsys_pkg::dread_req_t      core_rd,
    output logic [31:0]                     drdata,
    output logic                            wbusy,

    input  logic                            fetch_en,
    input  logic [$clog2(`MS_IC_LINES)-1:0] fetch_idx,
    output logic [127:0]                    fetch_data,
    output logic                            fetch_busy,

    output mem_subsys_pkg::ext_req_t        ext_req,
    input  mem_subsys_pkg::ext_rsp_t        ext_rsp,
    output logic                            xfer_done
);
    import mem_subsys_pkg::*;

    sram_port_t  dc_fill;
    sram_port_t  ic_fill;
    logic [31:0] dc_fill_rdata;

    mem_ctrl i_mem_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .dc_fill       (dc_fill),
        .ic_fill       (ic_fill),
        .dc_fill_rdata (dc_fill_rdata),
        .ext_req       (ext_req),
        .ext_rsp       (ext_rsp),
        .xfer_done     (xfer_done)
    );

    dcache_banks i_dcache (
        .clk        (clk),
        .arst_n     (arst_n),
        .fill       (dc_fill),
        .fill_rdata (dc_fill_rdata),
        .core_wr    (core_wr),
        .core_rd    (core_rd),
        .rdata      (drdata),
        .wbusy      (wbusy)
    );

    icache_array i_icache (
        .clk        (clk),
        .fill       (ic_fill),
        .fetch_en   (fetch_en),
        .fetch_idx  (fetch_idx),
        .fetch_data (fetch_data),
        .fetch_busy (fetch_busy)
    );

endmodule

//--- rtl/sram_2p.sv
`timescale 1ns/10ps

module sram_2p #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 512
) (
    input  logic                        clk,

    input  logic                        a_ce,
    input  logic                        a_we,
    input  logic [$bits(word_t)/8-1:0]  a_wm,
    input  logic [$clog2(DEPTH)-1:0]    a_addr,
    input  word_t                       a_wdata,
    output word_t                       a_rdata,

    input  logic                        b_ce,
    input  logic [$clog2(DEPTH)-1:0]    b_addr,
    output word_t                       b_rdata
);

    localparam int NBYTES = $bits(word_t) / 8;

    logic [$bits(word_t)-1:0] mem [DEPTH];

    // Port a, byte-masked write or read
    always_ff @(posedge clk) begin
        if (a_ce) begin
            if (a_we) begin
                for (int i = 0; i < NBYTES; i++) begin
                    if (a_wm[i]) begin
                        mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
                    end
                end
            end else begin
                a_rdata <= word_t'(mem[a_addr]);
            end
        end
    end

    // Port b, read only
    always_ff @(posedge clk) begin
        if (b_ce) begin
            b_rdata <= word_t'(mem[b_addr]);
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mem_subsys -f mem_subsys_top.f \
    --Mdir obj_dir -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_subsys +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tests/ext_mem_model.sv
`timescale 1ns/10ps

module ext_mem_model (
    input  logic                     clk,
    input  logic                     stall_en,

    // Preload port, used before any transfer
    input  logic                     ld_en,
    input  logic [6:0]               ld_addr,
    input  logic [31:0]              ld_data,

    input  mem_subsys_pkg::ext_req_t req,
    output mem_subsys_pkg::ext_rsp_t rsp
);

    localparam int WORDS = 128;

    logic [31:0] mem [WORDS];
    logic        stall_q = 1'b0;

    // About one cycle in four stalls when enabled
    always @(posedge clk) begin
        stall_q <= stall_en && ($urandom_range(3, 0) == 0);
        if (ld_en) begin
            mem[ld_addr] <= ld_data;
        end else if (req.en && req.we && !stall_q) begin
            mem[req.addr[6:0]] <= req.wdata;
        end
    end

    // Word address wraps inside the model
    assign rsp.stall = stall_q;
    assign rsp.rdata = mem[req.addr[6:0]];

endmodule

//--- tests/mem_subsys_props.sv
`timescale 1ns/10ps

module mem_subsys_props (
    input logic                       clk,
    input logic                       arst_n,
    input mem_subsys_pkg::ext_req_t   ext_req,
    input mem_subsys_pkg::ext_rsp_t   ext_rsp,
    input mem_subsys_pkg::sram_port_t dc_fill,
    input mem_subsys_pkg::sram_port_t ic_fill,
    input logic                       wbusy,
    input logic                       xfer_done
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // Request is frozen while the memory stalls
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ext_req.en && ext_rsp.stall |=> $stable(ext_req))
    else begin
        $error("ext_req changed while stall was high");
        fail_cnt++;
    end

    a_one_fill: assert property (@(posedge clk) disable iff (!arst_n)
        !(dc_fill.ce && ic_fill.ce))
    else begin
        $error("data and instruction fill ports active together");
        fail_cnt++;
    end

    // Write back-pressure only comes from the data fill port
    a_wbusy_fill: assert property (@(posedge clk) disable iff (!arst_n)
        wbusy |-> dc_fill.ce)
    else begin
        $error("wbusy high without an active data fill");
        fail_cnt++;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        xfer_done |=> !xfer_done)
    else begin
        $error("xfer_done longer than one cycle");
        fail_cnt++;
    end

endmodule

//--- tests/tb_mem_subsys.sv
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module tb_mem_subsys;
    import mem_subsys_pkg::*;

    localparam int XFER_WORDS = 40 + 40 + 24 + 8 + 30;
    localparam int EXT_WORDS  = 128;

    logic         clk = 1'b0;
    logic         arst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    sram_port_t   core_wr;
    dread_req_t   core_rd;
    logic [31:0]  drdata;
    logic         wbusy;
    logic         fetch_en;
    logic [7:0]   fetch_idx;
    logic [127:0] fetch_data;
    logic         fetch_busy;
    ext_req_t     ext_req;
    ext_rsp_t     ext_rsp;
    logic         xfer_done;
    logic         stall_en;
    logic         ld_en;
    logic [6:0]   ld_addr;
    logic [31:0]  ld_data;

    // Reference copies of external memory, data words and instruction words
    logic [31:0]  ext_sh [EXT_WORDS];
    logic [31:0]  dc_sh [1024];
    logic [31:0]  ic_sh [1024];
    string        cur_test;
    int           test_errors = 0;
    int           prop_seen = 0;
    int           n_pass = 0;
    int           n_fail = 0;
    logic [15:0]  done_exp = '0;

    always #2 clk = ~clk;

    mem_subsys_top i_dut (.*);

    ext_mem_model i_ext (
        .clk      (clk),
        .stall_en (stall_en),
        .ld_en    (ld_en),
        .ld_addr  (ld_addr),
        .ld_data  (ld_data),
        .req      (ext_req),
        .rsp      (ext_rsp)
    );

    bind mem_subsys_top mem_subsys_props i_props (
        .clk       (clk),
        .arst_n    (arst_n),
        .ext_req   (ext_req),
        .ext_rsp   (ext_rsp),
        .dc_fill   (dc_fill),
        .ic_fill   (ic_fill),
        .wbusy     (wbusy),
        .xfer_done (xfer_done)
    );

    function automatic void check_value(string what, logic [127:0] actual,
                                        logic [127:0] expected);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
            test_errors++;
        end
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                                logic [3:0] wm);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (wm[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic end_test();
        int errs;
        errs = test_errors + (i_dut.i_props.fail_cnt - prop_seen);
        prop_seen = i_dut.i_props.fail_cnt;
        if (errs == 0) begin
            n_pass++;
            $display("%s: passed", cur_test);
        end else begin
            n_fail++;
            $display("%s: failed with %0d errors", cur_test, errs);
        end
        test_errors = 0;
    endtask

    // ============================================================
    // APB master and register helpers
    // ============================================================
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_value("pready", apb_rsp.pready, 1'b1);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr", err, 1'b0);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value("pslverr", err, 1'b0);
    endtask

    task automatic reg_check(input logic [7:0] addr, input logic [31:0] value);
        logic [31:0] rd;
        reg_write(addr, value);
        reg_read(addr, rd);
        check_value($sformatf("reg %0h", addr), rd, value);
    endtask

    task automatic check_status(input logic busy);
        logic [31:0] rd;
        reg_read(`MS_REG_STATUS, rd);
        check_value("STATUS", rd, {done_exp, 15'd0, busy});
    endtask

    task automatic start_xfer(input int e, input int c, input int n, input logic [31:0] ctrl);
        reg_write(`MS_REG_EXT_ADDR, e);
        reg_write(`MS_REG_CACHE_ADDR, c);
        reg_write(`MS_REG_LEN, n);
        reg_write(`MS_REG_CTRL, ctrl);
    endtask

    task automatic wait_xfer_done();
        do @(negedge clk); while (!xfer_done);
        done_exp++;
    endtask

    task automatic apply_fill(input int e, input int c, input int n, input logic to_ic);
        for (int i = 0; i < n; i++) begin
            if (to_ic) begin
                ic_sh[(c + i) % 1024] = ext_sh[(e + i) % EXT_WORDS];
            end else begin
                dc_sh[(c + i) % 1024] = ext_sh[(e + i) % EXT_WORDS];
            end
        end
    endtask

    // ============================================================
    // Core data and fetch port helpers
    // ============================================================
    task automatic read_dword(input int addr);
        @(negedge clk);
        core_rd.re    = 1'b1;
        core_rd.raddr = 10'(addr);
        @(negedge clk);
        core_rd.re = 1'b0;
        check_value($sformatf("drdata[%0d]", addr), drdata, dc_sh[addr % 1024]);
    endtask

    // Write is held while wbusy and lands at the next rising edge
    task automatic write_dword(input int addr, input logic [31:0] data, input logic [3:0] wm,
                               output int held);
        held = 0;
        @(negedge clk);
        core_wr.ce   = 1'b1;
        core_wr.we   = 1'b1;
        core_wr.wm   = wm;
        core_wr.addr = 10'(addr);
        core_wr.data = data;
        #1;
        while (wbusy) begin
            held++;
            @(negedge clk);
            #1;
        end
        dc_sh[addr % 1024] = merge_bytes(dc_sh[addr % 1024], data, wm);
    endtask

    task automatic core_idle();
        @(negedge clk);
        core_wr = '0;
    endtask

    task automatic fetch_line(input int idx);
        @(negedge clk);
        fetch_en  = 1'b1;
        fetch_idx = 8'(idx);
        @(negedge clk);
        fetch_en = 1'b0;
        check_value($sformatf("fetch_data[%0d]", idx), fetch_data,
                    {ic_sh[idx*4+3], ic_sh[idx*4+2], ic_sh[idx*4+1], ic_sh[idx*4]});
    endtask

    initial begin
        repeat (XFER_WORDS * 20 + 2000) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic err;
        logic [31:0] rd;
        int e;
        int c;
        int n;
        int held;
        int held_total;
        void'($urandom(32'h565dfb2b));
        arst_n    = 1'b0;
        apb_req   = '0;
        core_wr   = '0;
        core_rd   = '0;
        fetch_en  = 1'b0;
        fetch_idx = '0;
        stall_en  = 1'b0;
        ld_en     = 1'b0;
        ld_addr   = '0;
        ld_data   = '0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        for (int a = 0; a < EXT_WORDS; a++) begin
            @(negedge clk);
            ld_en     = 1'b1;
            ld_addr   = 7'(a);
            ld_data   = $urandom;
            ext_sh[a] = ld_data;
        end
        @(negedge clk);
        ld_en = 1'b0;

        cur_test = "reset_and_regs";
        check_value("ext_req.en", ext_req.en, 1'b0);
        check_value("xfer_done", xfer_done, 1'b0);
        check_value("wbusy", wbusy, 1'b0);
        check_value("fetch_busy", fetch_busy, 1'b0);
        check_status(1'b0);
        reg_check(`MS_REG_EXT_ADDR, $urandom & 32'h3fff_ffff);
        reg_check(`MS_REG_CACHE_ADDR, $urandom_range(1023, 0));
        reg_check(`MS_REG_LEN, $urandom_range(1023, 1));
        reg_check(`MS_REG_CTRL, 32'h6);
        check_status(1'b0);
        apb_access(1'b0, 8'h14, 32'd0, rd, err);
        check_value("pslverr on read of 0x14", err, 1'b1);
        apb_access(1'b1, 8'h20, 32'h1, rd, err);
        check_value("pslverr on write of 0x20", err, 1'b1);
        end_test();

        cur_test = "data_fill";
        stall_en = 1'b1;
        n = $urandom_range(40, 1);
        e = $urandom_range(EXT_WORDS - 1, 0);
        c = $urandom_range(255, 0);
        start_xfer(e, c, n, 32'h1);
        wait_xfer_done();
        apply_fill(e, c, n, 1'b0);
        check_status(1'b0);
        for (int i = 0; i < n; i++) begin
            read_dword(c + i);
        end
        end_test();

        cur_test = "core_writes";
        stall_en = 1'b0;
        c = 400 + $urandom_range(63, 0);
        for (int i = 0; i < 24; i++) begin
            write_dword(c + i, $urandom, 4'hF, held);
        end
        for (int i = 0; i < 24; i++) begin
            write_dword(c + i, $urandom, 4'($urandom_range(15, 1)), held);
        end
        core_idle();
        // Masked writes race a 40-word fill into a separate range
        // All in one bank, so the alternating fill beats keep hitting them
        e = $urandom_range(EXT_WORDS - 1, 0);
        n = 600 + $urandom_range(63, 0);
        start_xfer(e, n, 40, 32'h1);
        held_total = 0;
        for (int i = 0; i < 8; i++) begin
            write_dword(c + i * 2, $urandom, 4'($urandom_range(15, 1)), held);
            held_total += held;
        end
        core_idle();
        wait_xfer_done();
        apply_fill(e, n, 40, 1'b0);
        assert (held_total > 0) else begin
            $display("%s: no core write was held off by the fill", cur_test);
            test_errors++;
        end
        for (int i = 0; i < 24; i++) begin
            read_dword(c + i);
        end
        for (int i = 0; i < 40; i++) begin
            read_dword(n + i);
        end
        check_status(1'b0);
        end_test();

        cur_test = "writeback";
        stall_en = 1'b1;
        e = $urandom_range(EXT_WORDS - 1, 0);
        start_xfer(e, c, 24, 32'h5);
        wait_xfer_done();
        for (int i = 0; i < 24; i++) begin
            ext_sh[(e + i) % EXT_WORDS] = dc_sh[(c + i) % 1024];
        end
        for (int a = 0; a < EXT_WORDS; a++) begin
            check_value($sformatf("ext[%0d]", a), i_ext.mem[a], ext_sh[a]);
        end
        check_status(1'b0);
        end_test();

        cur_test = "icache_fetch";
        e = $urandom_range(EXT_WORDS - 1, 0);
        n = $urandom_range(254, 0);
        start_xfer(e, n * 4, 8, 32'h3);
        wait_xfer_done();
        apply_fill(e, n * 4, 8, 1'b1);
        fetch_line(n);
        fetch_line(n + 1);
        check_status(1'b0);
        end_test();

        cur_test = "busy_guard";
        e = $urandom_range(EXT_WORDS - 1, 0);
        c = 800 + $urandom_range(63, 0);
        start_xfer(e, c, 30, 32'h1);
        check_status(1'b1);
        reg_write(`MS_REG_LEN, 32'd5);
        reg_write(`MS_REG_CTRL, 32'h5);
        wait_xfer_done();
        apply_fill(e, c, 30, 1'b0);
        check_status(1'b0);
        reg_read(`MS_REG_LEN, rd);
        check_value("LEN after busy write", rd, 32'd30);
        for (int i = 0; i < 30; i++) begin
            read_dword(c + i);
        end
        end_test();

        $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
